// File: fat32_file_reader.f
+incdir+include
hw/fat_fs_pkg.sv
hw/reader_ctrl_pkg.sv
hw/sector_if.sv
hw/block_reader.sv
hw/boot_sector_parser.sv
hw/dir_entry_matcher.sv
hw/cluster_walker.sv
hw/content_stream.sv
hw/fat32_file_reader.sv
tests/fat32_file_reader_tb.sv

// File: hw/block_reader.sv
/* Block device front end. Keeps at most one byte credit outstanding and
   expects exactly 512 bytes per request */
`timescale 1ns/1ps
`default_nettype none
`include "fat_defs.svh"

module block_reader (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    output logic                         rd_req,
    output fat_fs_pkg::sector_no_t       rd_sector,
    output logic                         rd_credit,
    input  wire logic                    rd_byte_valid,
    input  wire fat_fs_pkg::byte_t       rd_byte,
    sector_if.reader                     sec
);
    logic                            reading;  // sector in progress
    logic                            pending;  // credit out, byte not back yet
    reader_ctrl_pkg::sector_offset_t count;

    assign rd_req    = sec.req;
    assign rd_sector = sec.sector_no;

    assign sec.byte_valid = rd_byte_valid;
    assign sec.data       = rd_byte;
    assign sec.offset     = count;
    assign sec.last       = rd_byte_valid &&
        (count == reader_ctrl_pkg::sector_offset_t'(`FAT_SECTOR_BYTES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reading   <= 1'b0;
            pending   <= 1'b0;
            rd_credit <= 1'b0;
            count     <= '0;
        end else begin
            rd_credit <= 1'b0;
            if (sec.req) begin
                reading <= 1'b1;
                count   <= '0;
            end else if (rd_byte_valid) begin
                count   <= count + 1'b1;
                pending <= 1'b0;
                if (sec.last)
                    reading <= 1'b0;
            end else if (reading && !pending && (!sec.stream_mode || sec.room)) begin
                rd_credit <= 1'b1;   // next byte allowed
                pending   <= 1'b1;
            end
        end
    end
endmodule

`default_nettype wire

// File: hw/boot_sector_parser.sv
/* Latches the FAT32 boot fields of sector 0 as they stream past.
   The volume starts at sector 0, so reserved sectors give the first FAT */
`timescale 1ns/1ps
`default_nettype none
`include "fat_defs.svh"

module boot_sector_parser (
    input  wire logic               clk,
    input  wire logic               rst_n,
    sector_if.sink                  sec,
    input  wire logic               active,
    output fat_fs_pkg::geometry_t   geometry,
    output logic                    boot_ok
);
    fat_fs_pkg::byte_t      jump;
    logic [15:0]            bytes_per_sec;
    fat_fs_pkg::byte_t      sec_per_clus;
    logic [15:0]            rsvd_secs;
    fat_fs_pkg::byte_t      num_fats;
    logic [15:0]            fat_size16;    // must be zero on FAT32
    fat_fs_pkg::sector_no_t fat_size32;
    fat_fs_pkg::cluster_t   root_clus;
    logic [15:0]            signature;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jump <= '0;   // no valid boot sector until one is seen
        end else if (active && sec.byte_valid) begin
            case (sec.offset)
                9'h000: jump <= sec.data;
                9'h00b: bytes_per_sec[7:0]  <= sec.data;
                9'h00c: bytes_per_sec[15:8] <= sec.data;
                9'h00d: sec_per_clus <= sec.data;
                9'h00e: rsvd_secs[7:0]  <= sec.data;
                9'h00f: rsvd_secs[15:8] <= sec.data;
                9'h010: num_fats <= sec.data;
                9'h016: fat_size16[7:0]  <= sec.data;
                9'h017: fat_size16[15:8] <= sec.data;
                9'h024, 9'h025, 9'h026, 9'h027:
                    fat_size32[8*sec.offset[1:0] +: 8] <= sec.data;
                9'h02c, 9'h02d, 9'h02e, 9'h02f:
                    root_clus[8*sec.offset[1:0] +: 8] <= sec.data;
                9'h1fe: signature[15:8] <= sec.data;
                9'h1ff: signature[7:0]  <= sec.data;
                default: ;
            endcase
        end
    end

    always_comb begin
        geometry.sectors_per_cluster = sec_per_clus;
        geometry.first_fat_sector    = fat_fs_pkg::sector_no_t'(rsvd_secs);
        geometry.first_data_sector   = fat_fs_pkg::sector_no_t'(rsvd_secs)
            + fat_fs_pkg::sector_no_t'(num_fats) * fat_size32
            - (fat_fs_pkg::sector_no_t'(sec_per_clus) << 1);
        geometry.root_cluster        = {4'h0, root_clus[27:0]};
    end

    assign boot_ok = (bytes_per_sec == 16'(`FAT_SECTOR_BYTES)) && (fat_size16 == 16'h0)
        && (signature == 16'h55aa) && (jump == 8'heb || jump == 8'he9);
endmodule

`default_nettype wire

// File: hw/cluster_walker.sv
/* Walks the boot sector, the root directory chain and the file chain.
   One request per sector, issued one cycle after the registered last */
`timescale 1ns/1ps
`default_nettype none
`include "fat_defs.svh"

module cluster_walker (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    sector_if.walker                    sec,
    input  wire fat_fs_pkg::geometry_t  geometry,
    input  wire logic                   boot_ok,
    input  wire logic                   found,
    input  wire fat_fs_pkg::cluster_t   file_cluster,
    output logic                        parse_boot,
    output logic                        parse_dir,
    output logic                        done,
    output logic                        fs_error
);
    reader_ctrl_pkg::walk_state_t state;
    fat_fs_pkg::cluster_t         cluster;     // cluster being read
    fat_fs_pkg::byte_t            clus_sec;    // sector inside the cluster
    fat_fs_pkg::cluster_t         fat_entry;
    fat_fs_pkg::cluster_t         next_clus;
    logic                         started;
    logic                         seen_last;
    logic                         chain_end;
    logic                         clus_end;

    assign next_clus = {4'h0, fat_entry[27:0]};
    assign chain_end = next_clus < 32'd2 || next_clus >= `FAT_EOC_MIN;
    assign clus_end  = clus_sec == geometry.sectors_per_cluster - 8'd1;

    assign sec.stream_mode = state == reader_ctrl_pkg::READ_FILE;
    assign parse_boot      = state == reader_ctrl_pkg::BOOT;
    assign parse_dir       = state == reader_ctrl_pkg::LIST_ROOT;
    assign done     = state == reader_ctrl_pkg::DONE || state == reader_ctrl_pkg::FAIL;
    assign fs_error = state == reader_ctrl_pkg::FAIL;

    always_comb begin
        case (state)
            reader_ctrl_pkg::BOOT:       sec.sector_no = '0;
            reader_ctrl_pkg::FAT_LOOKUP: sec.sector_no = geometry.first_fat_sector
                + (cluster >> 7);        // 128 entries per FAT sector
            default:                     sec.sector_no = geometry.first_data_sector
                + cluster * geometry.sectors_per_cluster + clus_sec;
        endcase
    end

    // next-cluster entry sits at (cluster mod 128) * 4
    always_ff @(posedge clk) begin
        if (state == reader_ctrl_pkg::FAT_LOOKUP && sec.byte_valid
            && sec.offset[8:2] == cluster[6:0])
            fat_entry[8*sec.offset[1:0] +: 8] <= sec.data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= reader_ctrl_pkg::BOOT;
            cluster   <= '0;
            clus_sec  <= '0;
            started   <= 1'b0;
            seen_last <= 1'b0;
            sec.req   <= 1'b0;
        end else begin
            sec.req   <= 1'b0;
            seen_last <= sec.last;
            if (!started) begin
                started <= 1'b1;
                sec.req <= 1'b1;      // sector 0
            end else if (seen_last) begin
                case (state)
                    reader_ctrl_pkg::BOOT: begin
                        if (boot_ok) begin
                            state    <= reader_ctrl_pkg::LIST_ROOT;
                            cluster  <= geometry.root_cluster;
                            clus_sec <= '0;
                            sec.req  <= 1'b1;
                        end else begin
                            state <= reader_ctrl_pkg::FAIL;
                        end
                    end
                    reader_ctrl_pkg::LIST_ROOT, reader_ctrl_pkg::READ_FILE: begin
                        sec.req <= 1'b1;
                        if (state == reader_ctrl_pkg::LIST_ROOT && found) begin
                            state    <= reader_ctrl_pkg::READ_FILE;
                            cluster  <= {4'h0, file_cluster[27:0]};
                            clus_sec <= '0;
                        end else if (clus_end) begin
                            state <= reader_ctrl_pkg::FAT_LOOKUP;
                        end else begin
                            clus_sec <= clus_sec + 8'd1;
                        end
                    end
                    reader_ctrl_pkg::FAT_LOOKUP: begin
                        if (chain_end) begin
                            state <= reader_ctrl_pkg::DONE;  // end of file or of listing
                        end else begin
                            state    <= found ? reader_ctrl_pkg::READ_FILE
                                              : reader_ctrl_pkg::LIST_ROOT;
                            cluster  <= next_clus;
                            clus_sec <= '0;
                            sec.req  <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end
endmodule

`default_nettype wire

// File: hw/content_stream.sv
/* Output stage. Takes file bytes up to file_size into a small FIFO and
   sends one byte per stored credit; credits above the cap are dropped */
`timescale 1ns/1ps
`default_nettype none
`include "fat_defs.svh"

module content_stream (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    sector_if.sink                      sec,
    input  wire fat_fs_pkg::file_size_t file_size,
    output logic                        out_valid,
    output fat_fs_pkg::byte_t           out_byte,
    input  wire logic                   out_credit,
    output logic                        drained
);
    localparam int DEPTH = `FAT_OUT_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    fat_fs_pkg::byte_t        mem [DEPTH];
    logic [AW-1:0]            wr_ptr;
    logic [AW-1:0]            rd_ptr;
    logic [AW:0]              fill;
    fat_fs_pkg::file_size_t   count;      // file bytes taken so far
    reader_ctrl_pkg::credit_t credits;
    logic                     push;
    logic                     pop;

    assign push     = sec.byte_valid && sec.stream_mode && count < file_size;
    assign pop      = fill != '0 && credits != '0;
    assign sec.room = fill <= (AW+1)'(DEPTH - 2);
    assign drained  = count == file_size && fill == '0 && !out_valid;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= sec.data;
        if (pop)
            out_byte <= mem[rd_ptr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            count     <= '0;
            credits   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
                count  <= count + 32'd1;
            end
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            fill <= fill + (AW+1)'(push) - (AW+1)'(pop);
            if (out_credit && !pop
                && credits != reader_ctrl_pkg::credit_t'(`FAT_CREDIT_MAX))
                credits <= credits + 1'b1;
            else if (!out_credit && pop)
                credits <= credits - 1'b1;   // spent and returned cancel out
        end
    end
endmodule

`default_nettype wire

// File: hw/dir_entry_matcher.sv
/* Scans 32-byte directory entries for one upper-case 8.3 name.
   Only the first match is kept */
`timescale 1ns/1ps
`default_nettype none
`include "fat_defs.svh"

module dir_entry_matcher #(
    parameter fat_fs_pkg::fat_name_t TARGET_NAME = "README  TXT"
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    sector_if.sink                  sec,
    input  wire logic               active,
    output logic                    found,
    output fat_fs_pkg::cluster_t    file_cluster,
    output fat_fs_pkg::file_size_t  file_size
);
    logic [4:0]             ent;        // byte inside the entry
    fat_fs_pkg::byte_t      want;
    logic                   hit;        // this byte rules the entry out
    logic                   mismatch;
    fat_fs_pkg::cluster_t   cand_cluster;
    logic [23:0]            cand_size;  // size bytes 0 to 2

    assign ent = 5'(sec.offset % `FAT_DIR_ENTRY_BYTES);

    always_comb begin
        want = 8'h00;
        for (int i = 0; i < 11; i++)
            if (ent == 5'(i))
                want = TARGET_NAME[8*(10-i) +: 8];
    end

    always_comb begin
        hit = 1'b0;
        if (ent < 5'd11)
            hit = sec.data != want;
        if (ent == 5'd0)
            hit = hit || sec.data == 8'h00 || sec.data == 8'he5;  // free or deleted
        if (ent == 5'd11)
            hit = sec.data[3] || sec.data[4];   // volume label or directory
    end

    always_ff @(posedge clk) begin
        if (active && sec.byte_valid) begin
            case (ent)
                5'd20, 5'd21: cand_cluster[16 + 8*ent[0] +: 8] <= sec.data;
                5'd26, 5'd27: cand_cluster[8*ent[0] +: 8] <= sec.data;
                5'd28, 5'd29, 5'd30: cand_size[8*ent[1:0] +: 8] <= sec.data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mismatch     <= 1'b0;
            found        <= 1'b0;
            file_cluster <= '0;
            file_size    <= '0;
        end else if (active && sec.byte_valid) begin
            mismatch <= (ent == 5'd0) ? hit : (mismatch || hit);
            if (ent == 5'd31 && !mismatch && !found) begin
                found        <= 1'b1;
                file_cluster <= cand_cluster;
                file_size    <= {sec.data, cand_size};  // top byte arrives now
            end
        end
    end
endmodule

`default_nettype wire

// File: hw/fat32_file_reader.sv
/* FAT32 file reader behind a 512-byte block device. Volume at sector 0,
   target given as eleven upper-case 8.3 characters, space padded */
`timescale 1ns/1ps
`default_nettype none

module fat32_file_reader #(
    parameter fat_fs_pkg::fat_name_t TARGET_NAME = "README  TXT"
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    output logic                    rd_req,
    output fat_fs_pkg::sector_no_t  rd_sector,
    output logic                    rd_credit,
    input  wire logic               rd_byte_valid,
    input  wire fat_fs_pkg::byte_t  rd_byte,
    output logic                    out_valid,
    output fat_fs_pkg::byte_t       out_byte,
    input  wire logic               out_credit,
    output logic                    file_found,
    output logic                    done,
    output logic                    fs_error
);
    sector_if               sec ();
    fat_fs_pkg::geometry_t  geometry;
    fat_fs_pkg::cluster_t   file_cluster;
    fat_fs_pkg::file_size_t file_size;
    logic                   boot_ok;
    logic                   parse_boot;
    logic                   parse_dir;
    logic                   walk_done;
    logic                   drained;

    block_reader reader_i (.clk, .rst_n, .rd_req, .rd_sector, .rd_credit,
                           .rd_byte_valid, .rd_byte, .sec(sec.reader));

    boot_sector_parser boot_i (.clk, .rst_n, .sec(sec.sink), .active(parse_boot),
                               .geometry, .boot_ok);

    dir_entry_matcher #(.TARGET_NAME(TARGET_NAME)) dir_i (
        .clk, .rst_n, .sec(sec.sink), .active(parse_dir),
        .found(file_found), .file_cluster, .file_size);

    cluster_walker walker_i (.clk, .rst_n, .sec(sec.walker), .geometry, .boot_ok,
                             .found(file_found), .file_cluster, .parse_boot,
                             .parse_dir, .done(walk_done), .fs_error);

    content_stream stream_i (.clk, .rst_n, .sec(sec.sink), .file_size, .out_valid,
                             .out_byte, .out_credit, .drained);

    assign done = walk_done && drained;   // wait for the last byte to leave
endmodule

`default_nettype wire

// File: hw/fat_fs_pkg.sv
/* On-disk FAT32 types. Little-endian fields are assembled byte by byte,
   cluster numbers carry 28 valid bits */
`default_nettype none

package fat_fs_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] sector_no_t;
    typedef logic [31:0] cluster_t;    // top nibble reserved
    typedef logic [31:0] file_size_t;
    typedef logic [87:0] fat_name_t;   // first character in the msbs

    typedef struct packed {
        byte_t      sectors_per_cluster;
        sector_no_t first_fat_sector;
        sector_no_t first_data_sector;  // already moved back by two clusters
        cluster_t   root_cluster;
    } geometry_t;

endpackage

`default_nettype wire

// File: hw/reader_ctrl_pkg.sv
/* Controller types for the FAT32 reader */
`default_nettype none

package reader_ctrl_pkg;

    typedef enum logic [2:0] {
        BOOT,
        LIST_ROOT,
        READ_FILE,
        FAT_LOOKUP,
        DONE,
        FAIL
    } walk_state_t;

    typedef logic [8:0] sector_offset_t;  // byte inside a 512-byte sector
    typedef logic [3:0] credit_t;

endpackage

`default_nettype wire

// File: hw/sector_if.sv
/* Sector byte stream shared by the block reader, the walker and the
   parsers. room is driven by the output stage only */
`timescale 1ns/1ps
`default_nettype none

interface sector_if;
    logic                            req;
    fat_fs_pkg::sector_no_t          sector_no;
    logic                            byte_valid;
    reader_ctrl_pkg::sector_offset_t offset;
    fat_fs_pkg::byte_t               data;
    logic                            last;
    logic                            stream_mode;
    logic                            room;

    modport reader (input req, sector_no, stream_mode, room,
                    output byte_valid, offset, data, last);
    modport walker (output req, sector_no, stream_mode,
                    input byte_valid, offset, data, last);
    modport sink   (input byte_valid, offset, data, last, stream_mode, output room);
endinterface

`default_nettype wire

// File: include/fat_defs.svh
/* FAT32 reader constants. Only 512-byte sectors are accepted.
   FIFO depth must stay a power of two, credit cap fits in credit_t */
`ifndef FAT_DEFS_SVH
`define FAT_DEFS_SVH

// on-disk format
`define FAT_SECTOR_BYTES     512
`define FAT_DIR_ENTRY_BYTES  32
`define FAT_EOC_MIN          32'h0FFF_FFF8

// output side
`define FAT_OUT_FIFO_DEPTH   4
`define FAT_CREDIT_MAX       15

`endif

// File: tests/fat32_file_reader_tb.sv
/* Testbench for the FAT32 file reader. Images, credit patterns and expected
   output come from tests/fat32_tests.mem, read relative to the project root.
   Fill records of later images patch the earlier ones */
`timescale 1ns/1ps
`default_nettype none
`include "fat_defs.svh"

module fat32_file_reader_tb;
    localparam int MAX_WORDS = 512;

    logic        clk;
    logic        rst_n;
    logic        rd_req;
    logic [31:0] rd_sector;
    logic        rd_credit;
    logic        rd_byte_valid;
    logic [7:0]  rd_byte;
    logic        out_valid;
    logic [7:0]  out_byte;
    logic        out_credit;
    logic        file_found;
    logic        done;
    logic        fs_error;

    logic [31:0] words [MAX_WORDS];

    int          fill_img[$];
    int          fill_sec[$];
    int          fill_off[$];
    int          fill_len[$];
    logic [31:0] fill_pat[$];   // bytes taken lsb first, repeated
    int          run_img[$];
    int          run_cnt[$];
    logic [7:0]  run_val[$];
    logic [31:0] img_mask[$];
    int          img_found[$];
    int          img_error[$];
    int          img_reads[$];

    logic [7:0]  expect_q[$];
    logic [31:0] credit_mask;
    int          cur_img;
    int          cycle;
    int          given;         // credits handed to the DUT
    int          received;      // bytes seen on out_valid
    int          reads;
    bit          dev_busy;
    logic [31:0] dev_sector;
    int          dev_pos;
    int          dev_wait;
    int          dev_credits;
    integer      seed;
    int          errors;
    int          checks;
    int          limit_cycles = 0;

    fat32_file_reader #(.TARGET_NAME("README  TXT")) dut_i (
        .clk, .rst_n, .rd_req, .rd_sector, .rd_credit, .rd_byte_valid, .rd_byte,
        .out_valid, .out_byte, .out_credit, .file_found, .done, .fs_error);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // last matching fill record wins, unwritten bytes read as zero
    function automatic logic [7:0] image_byte(input int img, input logic [31:0] sector,
                                              input int pos);
        logic [7:0] b;
        int         k;
        b = 8'h00;
        for (int i = 0; i < fill_sec.size(); i++) begin
            if (fill_img[i] <= img && fill_sec[i] == sector
                && pos >= fill_off[i] && pos < fill_off[i] + fill_len[i]) begin
                k = (pos - fill_off[i]) % 4;
                b = 8'(fill_pat[i] >> (8 * k));
            end
        end
        return b;
    endfunction

    task automatic load_tests();
        int          p;
        int          img;
        logic [31:0] mask;
        for (int i = 0; i < MAX_WORDS; i++)
            words[i] = '0;
        $readmemh("tests/fat32_tests.mem", words);
        p = 0;
        img = 0;
        mask = '1;
        while (p < MAX_WORDS && words[p] != 32'd0) begin
            case (words[p])
                32'd1: begin
                    fill_img.push_back(img);
                    fill_sec.push_back(words[p+1]);
                    fill_off.push_back(words[p+2]);
                    fill_len.push_back(words[p+3]);
                    fill_pat.push_back(words[p+4]);
                    p += 5;
                end
                32'd2: begin
                    mask = words[p+1];
                    p += 2;
                end
                32'd3: begin
                    run_img.push_back(img);
                    run_cnt.push_back(words[p+1]);
                    run_val.push_back(words[p+2][7:0]);
                    limit_cycles += 40 * words[p+1];
                    p += 3;
                end
                32'd4: begin
                    img_found.push_back(words[p+1]);
                    img_error.push_back(words[p+2]);
                    img_reads.push_back(words[p+3]);
                    img_mask.push_back(mask);
                    limit_cycles += 2000 * words[p+3] + 200;   // slow sector reads
                    mask = '1;
                    img++;
                    p += 4;
                end
                default: begin
                    report_failure("unknown record type in the test data file");
                    p = MAX_WORDS;
                end
            endcase
        end
        if (img == 0)
            report_failure("the test data file holds no image");
    endtask

    // one clock of block device model and output sink, on the falling edge
    task automatic run_cycle();
        @(negedge clk);
        cycle++;
        rd_byte_valid = 1'b0;
        out_credit = 1'b0;
        if (!rst_n) begin
            dev_busy = 1'b0;
            dev_credits = 0;
        end else begin
            if (out_valid) begin
                received++;
                if (received > given)
                    report_failure("output byte sent without a credit");
                if (expect_q.size() == 0)
                    report_failure("output byte beyond the end of the expected data");
                else
                    check_value("out_byte", out_byte, expect_q.pop_front());
            end
            if (credit_mask[cycle % 32] && given - received < `FAT_CREDIT_MAX) begin
                out_credit = 1'b1;
                given++;
            end
            if (rd_req) begin
                reads++;
                if (dev_busy)
                    report_failure("sector request while a sector read is still running");
                dev_busy = 1'b1;
                dev_sector = rd_sector;
                dev_pos = 0;
                dev_credits = 0;
                dev_wait = $random(seed) & 15;   // access latency
            end
            if (rd_credit) begin
                dev_credits++;
                if (!dev_busy || dev_pos + dev_credits > `FAT_SECTOR_BYTES)
                    report_failure("byte credit outside a sector read");
                if (dev_credits > 1)
                    report_failure("more than one byte credit outstanding");
            end
            if (dev_wait > 0) begin
                dev_wait--;
            end else if (dev_busy && dev_credits > 0) begin
                rd_byte_valid = 1'b1;
                rd_byte = image_byte(cur_img, dev_sector, dev_pos);
                dev_pos++;
                dev_credits--;
                dev_wait = $random(seed) & 1;
                if (dev_pos == `FAT_SECTOR_BYTES)
                    dev_busy = 1'b0;
            end
        end
    endtask

    task automatic run_image(input int img);
        int total;
        cur_img = img;
        credit_mask = img_mask[img];
        expect_q.delete();
        for (int i = 0; i < run_cnt.size(); i++)
            if (run_img[i] == img)
                repeat (run_cnt[i]) expect_q.push_back(run_val[i]);
        total = expect_q.size();
        rst_n = 1'b0;
        repeat (5) run_cycle();
        rst_n = 1'b1;
        reads = 0;
        given = 0;
        received = 0;
        while (!done)
            run_cycle();
        check_value("output bytes at done", received, total);   // last byte left first
        repeat (20) run_cycle();   // quiet after done
        check_value("done", done, 1);
        check_value("file_found", file_found, img_found[img]);
        check_value("fs_error", fs_error, img_error[img]);
        check_value("sector reads", reads, img_reads[img]);
        check_value("output bytes", received, total);
    endtask

    initial begin
        rst_n = 1'b0;
        rd_byte_valid = 1'b0;
        rd_byte = 8'h00;
        out_credit = 1'b0;
        seed = 26326;
        errors = 0;
        checks = 0;
        cycle = 0;
        load_tests();
        for (int n = 0; n < img_found.size(); n++)
            run_image(n);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin
        @(posedge clk);   // test data loaded by now
        repeat (limit_cycles + 100) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", limit_cycles);
        $display("Some tests failed");
        $finish;
    end
endmodule

`default_nettype wire

// File: tests/fat32_tests.mem
// hex records, one per line, fill records of an image carry into the next
// 1 sector offset length pattern : fill, pattern bytes lsb first, repeated
// 2 mask : out_credit on cycles whose bit (cycle mod 32) is set
// 3 count value : expected output run
// 4 found error reads : end of image with expected flags and sector reads
// 0 : end of data
// image 0: 600-byte file in clusters 5 and 6, sparse credits
1 0 0 1 eb
1 0 b 4 02010200
1 0 f 2 0100
1 0 24 4 1
1 0 2c 4 2
1 0 1fe 2 aa55
1 2 8 4 0fffffff
1 2 14 4 6
1 2 18 4 0fffffff
1 3 0 4 44414552
1 3 4 4 2020454d
1 3 8 4 20545854
1 3 1a 4 02580005
1 6 0 100 11111111
1 6 100 100 22222222
1 7 0 58 3c3c3c3c
1 7 58 1a8 77777777
2 01010101
3 100 11
3 100 22
3 58 3c
4 1 0 6
// image 1: deleted entry and directory of the same name, target in root cluster 3
1 3 0 1 e5
1 3 20 4 44414552
1 3 24 4 2020454d
1 3 28 4 10545854
1 2 8 4 3
1 2 c 4 0fffffff
1 4 40 4 44414552
1 4 44 4 2020454d
1 4 48 4 20545854
1 4 5a 4 00640008
1 2 20 4 0fffffff
1 9 0 64 5a5a5a5a
1 9 64 19c 66666666
2 ffffffff
3 64 5a
4 1 0 6
// image 2: target deleted, name absent
1 4 40 1 e5
2 55555555
4 0 0 5
// image 3: 1024-byte sectors
1 0 b 2 0400
4 0 1 1
// image 4: 512-byte sectors, signature missing
1 0 b 2 0200
1 0 1fe 2 0
4 0 1 1
0
